//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_ahb_matrix
FILELIST  := ahb_matrix_sys.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

SOURCES   := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ahb_matrix_sys.f
+incdir+rtl
rtl/ahb_bus_pkg.sv
rtl/board_io_pkg.sv
rtl/ahb_addr_decoder.sv
rtl/ahb_ram_slave.sv
rtl/ahb_gpio_slave.sv
rtl/ahb_response_mux.sv
rtl/ahb_lite_matrix.sv
tb/tb_ahb_matrix.sv

//--- rtl/ahb_addr_decoder.sv
`timescale 1ns/1ps

`include "ahb_matrix_params.svh"

module ahb_addr_decoder (
    input  ahb_bus_pkg::haddr_t     haddr,
    output ahb_bus_pkg::slave_sel_t hsel
);

    import ahb_bus_pkg::*;

    // Bits 31..29 are the segment bits and are ignored.
    always_comb begin
        hsel = '0;
        hsel[SEL_BOOT] = (haddr[28:22] == `AHB_BOOT_MATCH);
        hsel[SEL_RAM]  = (haddr[28] == `AHB_RAM_MATCH);
        hsel[SEL_GPIO] = (haddr[28:22] == `AHB_GPIO_MATCH);
    end

endmodule

//--- rtl/ahb_bus_pkg.sv
package ahb_bus_pkg;

    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [2:0]  hsize_t;
    typedef logic [2:0]  slave_sel_t;  // One-hot, zero when nothing matches.

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [1:0] {
        OKAY,
        ERR_FIRST,
        ERR_SECOND
    } resp_state_t;

    localparam hsize_t SIZE_BYTE = 3'b000;
    localparam hsize_t SIZE_HALF = 3'b001;
    localparam hsize_t SIZE_WORD = 3'b010;

    localparam int SEL_BOOT = 0;
    localparam int SEL_RAM  = 1;
    localparam int SEL_GPIO = 2;

endpackage

//--- rtl/ahb_gpio_slave.sv
`timescale 1ns/1ps

`include "ahb_matrix_params.svh"

module ahb_gpio_slave (
    input  logic                       HCLK,
    input  logic                       rst_n,
    input  logic                       sel,
    input  ahb_bus_pkg::haddr_t         haddr,
    input  ahb_bus_pkg::htrans_t        htrans,
    input  logic                       hwrite,
    input  ahb_bus_pkg::hdata_t         hwdata,
    input  logic                       hready,
    output ahb_bus_pkg::hdata_t         rdata,
    output logic                       ready,
    input  board_io_pkg::switches_t     switches,
    input  board_io_pkg::buttons_t      buttons,
    output board_io_pkg::red_leds_t     red_leds,
    output board_io_pkg::green_leds_t   green_leds,
    output board_io_pkg::hex_t          hex
);

    import ahb_bus_pkg::*;
    import board_io_pkg::*;

    logic                        xfer;
    logic                        dphase_q;
    logic                        write_q;
    logic                        rd_wait_q;
    logic                        rd_pend;
    logic [`GPIO_OFS_WIDTH-1:0]  ofs_q;
    hdata_t                      rd_value;
    hdata_t                      rdata_q;

    switches_t                   sw_meta;
    switches_t                   sw_sync;
    buttons_t                    btn_meta;
    buttons_t                    btn_sync;

    assign xfer = hready && sel && (htrans == NONSEQ || htrans == SEQ);

    // ====================
    // Input synchronizers
    // ====================
    always_ff @(posedge HCLK) begin
        sw_meta  <= switches;
        sw_sync  <= sw_meta;
        btn_meta <= buttons;
        btn_sync <= btn_meta;
    end

    // ====================
    // Bus control
    // ====================
    assign rd_pend = dphase_q && !write_q;
    assign ready   = !(rd_pend && !rd_wait_q);  // Low for the first read cycle.

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            dphase_q  <= 1'b0;
            write_q   <= 1'b0;
            rd_wait_q <= 1'b0;
        end else if (hready) begin
            dphase_q  <= xfer;
            write_q   <= hwrite;
            rd_wait_q <= 1'b0;
        end else if (rd_pend) begin
            rd_wait_q <= 1'b1;
        end
    end

    always_ff @(posedge HCLK) begin
        if (xfer) begin
            ofs_q <= haddr[`GPIO_OFS_WIDTH-1:0];
        end
        if (rd_pend && !rd_wait_q) begin
            rdata_q <= rd_value;  // Captured during the wait state.
        end
    end

    always_comb begin
        case (ofs_q)
            `GPIO_RED_OFS:   rd_value = hdata_t'(red_leds);
            `GPIO_GREEN_OFS: rd_value = hdata_t'(green_leds);
            `GPIO_HEX_OFS:   rd_value = hdata_t'(hex);
            `GPIO_SW_OFS:    rd_value = hdata_t'(sw_sync);
            `GPIO_BTN_OFS:   rd_value = hdata_t'(btn_sync);
            default:         rd_value = '0;
        endcase
    end

    assign rdata = rdata_q;

    // ====================
    // Output registers
    // ====================
    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            red_leds   <= '0;
            green_leds <= '0;
            hex        <= '0;
        end else if (dphase_q && write_q && hready) begin
            case (ofs_q)
                `GPIO_RED_OFS:   red_leds   <= hwdata[$bits(red_leds_t)-1:0];
                `GPIO_GREEN_OFS: green_leds <= hwdata[$bits(green_leds_t)-1:0];
                `GPIO_HEX_OFS:   hex        <= hwdata[$bits(hex_t)-1:0];
                default:         ;  // Input offsets are read-only.
            endcase
        end
    end

endmodule

//--- rtl/ahb_lite_matrix.sv
`timescale 1ns/1ps

`include "ahb_matrix_params.svh"

module ahb_lite_matrix (
    input  logic                       HCLK,
    input  logic                       rst_n,
    input  ahb_bus_pkg::haddr_t         haddr,
    input  ahb_bus_pkg::htrans_t        htrans,
    input  ahb_bus_pkg::hsize_t         hsize,
    input  logic                       hwrite,
    input  ahb_bus_pkg::hdata_t         hwdata,
    output ahb_bus_pkg::hdata_t         hrdata,
    output logic                       hready,
    output logic                       hresp,
    input  board_io_pkg::switches_t     switches,
    input  board_io_pkg::buttons_t      buttons,
    output board_io_pkg::red_leds_t     red_leds,
    output board_io_pkg::green_leds_t   green_leds,
    output board_io_pkg::hex_t          hex
);

    import ahb_bus_pkg::*;

    slave_sel_t  hsel;
    hdata_t      boot_rdata;
    hdata_t      ram_rdata;
    hdata_t      gpio_rdata;
    logic        boot_ready;
    logic        ram_ready;
    logic        gpio_ready;

    // ====================
    // Decode stage
    // ====================
    ahb_addr_decoder decoder (
        .haddr  (haddr),
        .hsel   (hsel)
    );

    // ====================
    // Execute stage
    // ====================
    ahb_ram_slave #(
        .ADDR_WIDTH (`AHB_BOOT_ADDR_WIDTH)
    ) boot_ram (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .sel    (hsel[SEL_BOOT]),
        .haddr  (haddr),
        .htrans (htrans),
        .hsize  (hsize),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hready (hready),
        .rdata  (boot_rdata),
        .ready  (boot_ready)
    );

    ahb_ram_slave #(
        .ADDR_WIDTH (`AHB_RAM_ADDR_WIDTH)
    ) main_ram (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .sel    (hsel[SEL_RAM]),
        .haddr  (haddr),
        .htrans (htrans),
        .hsize  (hsize),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hready (hready),
        .rdata  (ram_rdata),
        .ready  (ram_ready)
    );

    ahb_gpio_slave gpio (
        .HCLK       (HCLK),
        .rst_n      (rst_n),
        .sel        (hsel[SEL_GPIO]),
        .haddr      (haddr),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hready     (hready),
        .rdata      (gpio_rdata),
        .ready      (gpio_ready),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds),
        .hex        (hex)
    );

    // ====================
    // Result stage
    // ====================
    ahb_response_mux response_mux (
        .HCLK       (HCLK),
        .rst_n      (rst_n),
        .hsel       (hsel),
        .htrans     (htrans),
        .boot_rdata (boot_rdata),
        .boot_ready (boot_ready),
        .ram_rdata  (ram_rdata),
        .ram_ready  (ram_ready),
        .gpio_rdata (gpio_rdata),
        .gpio_ready (gpio_ready),
        .hrdata     (hrdata),
        .hready     (hready),
        .hresp      (hresp)
    );

endmodule

//--- rtl/ahb_matrix_params.svh
`ifndef AHB_MATRIX_PARAMS_SVH
`define AHB_MATRIX_PARAMS_SVH

// ====================
// Address map
// ====================
`define AHB_BOOT_MATCH       7'h7F  // Physical 0x1FC00000, bits 28..22.
`define AHB_GPIO_MATCH       7'h7E  // Physical 0x1F800000, bits 28..22.
`define AHB_RAM_MATCH        1'b0   // Bit 28 low selects main RAM.

`define AHB_BOOT_ADDR_WIDTH  10     // Word address bits.
`define AHB_RAM_ADDR_WIDTH   12

// ====================
// GPIO registers
// ====================
`define GPIO_OFS_WIDTH       5
`define GPIO_RED_OFS         5'h00
`define GPIO_GREEN_OFS       5'h04
`define GPIO_HEX_OFS         5'h08
`define GPIO_SW_OFS          5'h0C
`define GPIO_BTN_OFS         5'h10

`define IO_N_SWITCHES        16
`define IO_N_BUTTONS         4
`define IO_N_RED_LEDS        16
`define IO_N_GREEN_LEDS      8
`define IO_HEX_WIDTH         32     // Eight 4-bit digits.

`endif

//--- rtl/ahb_ram_slave.sv
`timescale 1ns/1ps

module ahb_ram_slave #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                HCLK,
    input  logic                rst_n,
    input  logic                sel,
    input  ahb_bus_pkg::haddr_t  haddr,
    input  ahb_bus_pkg::htrans_t htrans,
    input  ahb_bus_pkg::hsize_t  hsize,
    input  logic                hwrite,
    input  ahb_bus_pkg::hdata_t  hwdata,
    input  logic                hready,
    output ahb_bus_pkg::hdata_t  rdata,
    output logic                ready
);

    import ahb_bus_pkg::*;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    hdata_t                  mem [0:DEPTH-1];

    logic                    xfer;
    logic                    dphase_q;
    logic                    write_q;
    logic [ADDR_WIDTH-1:0]   waddr_q;
    logic [3:0]              lanes_q;

    // Byte lanes for a little-endian bus.
    function automatic logic [3:0] lane_mask(input hsize_t size, input logic [1:0] ofs);
        logic [3:0] mask;
        case (size)
            SIZE_BYTE: mask = 4'b0001 << ofs;
            SIZE_HALF: mask = ofs[1] ? 4'b1100 : 4'b0011;
            default:   mask = 4'b1111;
        endcase
        return mask;
    endfunction

    assign xfer = hready && sel && (htrans == NONSEQ || htrans == SEQ);

    // ====================
    // Address phase
    // ====================
    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            dphase_q <= 1'b0;
            write_q  <= 1'b0;
        end else if (hready) begin
            dphase_q <= xfer;
            write_q  <= hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (xfer) begin
            waddr_q <= haddr[ADDR_WIDTH+1:2];
            lanes_q <= lane_mask(hsize, haddr[1:0]);
        end
    end

    // ====================
    // Data phase
    // ====================
    always_ff @(posedge HCLK) begin
        if (dphase_q && write_q && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes_q[i]) begin
                    mem[waddr_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata = mem[waddr_q];  // Sees a write committed on the previous edge.
    assign ready = 1'b1;          // Zero wait states.

    // Halfword and word transfers must be naturally aligned.
    assert property (@(posedge HCLK) disable iff (!rst_n)
        xfer |-> ((hsize == SIZE_BYTE)
              || (hsize == SIZE_HALF && !haddr[0])
              || (hsize == SIZE_WORD && haddr[1:0] == 2'b00)))
    else $error("ERR unaligned RAM access at %h size %0d", haddr, hsize);

endmodule

//--- rtl/ahb_response_mux.sv
`timescale 1ns/1ps

module ahb_response_mux (
    input  logic                     HCLK,
    input  logic                     rst_n,
    input  ahb_bus_pkg::slave_sel_t  hsel,
    input  ahb_bus_pkg::htrans_t     htrans,
    input  ahb_bus_pkg::hdata_t      boot_rdata,
    input  logic                     boot_ready,
    input  ahb_bus_pkg::hdata_t      ram_rdata,
    input  logic                     ram_ready,
    input  ahb_bus_pkg::hdata_t      gpio_rdata,
    input  logic                     gpio_ready,
    output ahb_bus_pkg::hdata_t      hrdata,
    output logic                     hready,
    output logic                     hresp
);

    import ahb_bus_pkg::*;

    slave_sel_t   owner_q;  // Slave that owns the current data phase.
    resp_state_t  state;
    logic         xfer;
    hdata_t       mux_rdata;
    logic         mux_ready;

    assign xfer = (htrans == NONSEQ) || (htrans == SEQ);

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            owner_q <= '0;
            state   <= OKAY;
        end else begin
            if (hready) begin
                owner_q <= xfer ? hsel : '0;
            end
            case (state)
                ERR_FIRST: state <= ERR_SECOND;
                default: begin
                    if (hready && xfer && hsel == '0) begin
                        state <= ERR_FIRST;  // Unmapped address.
                    end else begin
                        state <= OKAY;
                    end
                end
            endcase
        end
    end

    always_comb begin
        mux_rdata = '0;
        mux_ready = 1'b1;
        if (owner_q[SEL_BOOT]) begin
            mux_rdata = boot_rdata;
            mux_ready = boot_ready;
        end else if (owner_q[SEL_RAM]) begin
            mux_rdata = ram_rdata;
            mux_ready = ram_ready;
        end else if (owner_q[SEL_GPIO]) begin
            mux_rdata = gpio_rdata;
            mux_ready = gpio_ready;
        end
    end

    always_comb begin
        case (state)
            ERR_FIRST: begin
                hrdata = '0;
                hready = 1'b0;
                hresp  = 1'b1;
            end
            ERR_SECOND: begin
                hrdata = '0;
                hready = 1'b1;
                hresp  = 1'b1;
            end
            default: begin
                hrdata = mux_rdata;
                hready = mux_ready;
                hresp  = 1'b0;
            end
        endcase
    end

    // A waited address phase stays on the bus until hready rises.
    assert property (@(posedge HCLK) disable iff (!rst_n)
        !hready && xfer |=> $stable(hsel) && $stable(htrans))
    else $error("ERR address phase changed while hready was low");

endmodule

//--- rtl/board_io_pkg.sv
`include "ahb_matrix_params.svh"

package board_io_pkg;

    // ====================
    // Board I/O vectors
    // ====================
    typedef logic [`IO_N_SWITCHES-1:0]   switches_t;
    typedef logic [`IO_N_BUTTONS-1:0]    buttons_t;
    typedef logic [`IO_N_RED_LEDS-1:0]   red_leds_t;
    typedef logic [`IO_N_GREEN_LEDS-1:0] green_leds_t;

    // Digit n sits in bits 4n+3..4n.
    typedef logic [`IO_HEX_WIDTH-1:0]    hex_t;

endpackage

//--- tb/tb_ahb_matrix.sv
`timescale 1ns/1ps

`include "ahb_matrix_params.svh"

module tb_ahb_matrix;

    import ahb_bus_pkg::*;
    import board_io_pkg::*;

    localparam int WIN     = 16;  // Words used in each RAM region.
    localparam int TIMEOUT = 20;
    localparam int K_BOOT  = 0;
    localparam int K_RAM   = 1;
    localparam int K_GPIO  = 2;
    localparam int K_ERR   = 3;

    localparam haddr_t BOOT_BASE = 32'h1FC0_0000;
    localparam haddr_t RAM_BASE  = 32'h0000_0000;
    localparam haddr_t GPIO_BASE = 32'h1F80_0000;
    localparam haddr_t HOLE_BASE = 32'h1F00_0000;  // Matches no slave.

    logic        HCLK;
    logic        rst_n;
    haddr_t      haddr;
    htrans_t     htrans;
    hsize_t      hsize;
    logic        hwrite;
    hdata_t      hwdata;
    hdata_t      hrdata;
    logic        hready;
    logic        hresp;
    switches_t   switches;
    buttons_t    buttons;
    red_leds_t   red_leds;
    green_leds_t green_leds;
    hex_t        hex;

    // ====================
    // Reference model
    // ====================
    hdata_t      boot_mem [0:WIN-1];
    hdata_t      ram_mem  [0:WIN-1];
    red_leds_t   red_m;
    green_leds_t green_m;
    hex_t        hex_m;
    switches_t   sw_q1;
    switches_t   sw_q2;
    buttons_t    btn_q1;
    buttons_t    btn_q2;

    // Transfer in the data phase and in the address phase.
    logic        d_valid;
    int          d_kind;
    logic        d_write;
    haddr_t      d_addr;
    hsize_t      d_size;
    hdata_t      d_wdata;
    logic        a_valid;
    int          a_kind;
    logic        a_write;
    haddr_t      a_addr;
    hsize_t      a_size;
    hdata_t      a_wdata;

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    logic        timed_out;

    ahb_lite_matrix dut_i (
        .HCLK       (HCLK),
        .rst_n      (rst_n),
        .haddr      (haddr),
        .htrans     (htrans),
        .hsize      (hsize),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .hready     (hready),
        .hresp      (hresp),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds),
        .hex        (hex)
    );

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    // Two-flop delay seen by GPIO reads.
    always @(posedge HCLK) begin
        sw_q1  <= switches;
        sw_q2  <= sw_q1;
        btn_q1 <= buttons;
        btn_q2 <= btn_q1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic hdata_t lane_merge(input hdata_t old, input hdata_t wdata,
                                          input hsize_t size, input logic [1:0] ofs);
        hdata_t     result;
        logic [1:0] lane;
        result = old;
        for (int b = 0; b < 4; b++) begin
            lane = 2'(b);
            if (size == SIZE_WORD || (size == SIZE_HALF && lane[1] == ofs[1])
                || (size == SIZE_BYTE && lane == ofs)) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic haddr_t region_base(input int kind);
        return (kind == K_BOOT) ? BOOT_BASE : RAM_BASE;
    endfunction

    task automatic check_board_outputs();
        checks++;
        assert (red_leds === red_m && green_leds === green_m && hex === hex_m) else begin
            errors++;
            $display("ERR %0t: board outputs %h %h %h, expected %h %h %h", $time,
                     red_leds, green_leds, hex, red_m, green_m, hex_m);
        end
    endtask

    // ====================
    // Data-phase checks
    // ====================
    task automatic complete_data(input int waits, input logic resp_wait, input logic resp_end,
                                 input hdata_t rdata, input switches_t sw_snap,
                                 input buttons_t btn_snap);
        int          exp_waits;
        logic        exp_resp;
        resp_state_t exp_state;
        hdata_t      exp_rdata;
        int          idx;
        logic [4:0]  ofs;
        exp_resp  = (d_kind == K_ERR);
        exp_state = exp_resp ? ERR_FIRST : OKAY;
        exp_waits = (exp_resp || (d_kind == K_GPIO && !d_write)) ? 1 : 0;
        exp_rdata = '0;
        idx       = int'(d_addr[5:2]);
        ofs       = d_addr[4:0];
        if (d_kind == K_BOOT) begin
            if (d_write) boot_mem[idx] = lane_merge(boot_mem[idx], d_wdata, d_size, ofs[1:0]);
            else exp_rdata = boot_mem[idx];
        end else if (d_kind == K_RAM) begin
            if (d_write) ram_mem[idx] = lane_merge(ram_mem[idx], d_wdata, d_size, ofs[1:0]);
            else exp_rdata = ram_mem[idx];
        end else if (d_kind == K_GPIO && d_write) begin
            case (ofs)
                `GPIO_RED_OFS:   red_m   = d_wdata[15:0];
                `GPIO_GREEN_OFS: green_m = d_wdata[7:0];
                `GPIO_HEX_OFS:   hex_m   = d_wdata;
                default:         ;  // Switch and button offsets are read-only.
            endcase
        end else if (d_kind == K_GPIO) begin
            case (ofs)
                `GPIO_RED_OFS:   exp_rdata = 32'(red_m);
                `GPIO_GREEN_OFS: exp_rdata = 32'(green_m);
                `GPIO_HEX_OFS:   exp_rdata = hex_m;
                `GPIO_SW_OFS:    exp_rdata = 32'(sw_snap);
                `GPIO_BTN_OFS:   exp_rdata = 32'(btn_snap);
                default:         exp_rdata = '0;
            endcase
        end
        checks += 2;
        assert (waits == exp_waits) else begin
            errors++;
            $display("ERR %0t: %h took %0d wait states, expected %0d", $time, d_addr,
                     waits, exp_waits);
        end
        assert (resp_wait == exp_resp && resp_end == exp_resp) else begin
            errors++;
            $display("ERR %0t: hresp %b then %b at %h, expected %s response", $time,
                     resp_wait, resp_end, d_addr, exp_state.name());
        end
        if (!d_write) begin
            checks++;
            assert (rdata === exp_rdata) else begin
                errors++;
                $display("ERR %0t: read %h returned %h, expected %h", $time, d_addr,
                         rdata, exp_rdata);
            end
        end
    endtask

    // ====================
    // Bus driver
    // ====================
    // Waits for the current data phase to end, then puts the next address phase on the bus.
    task automatic bus_step(input logic valid, input int kind, input logic write,
                            input haddr_t addr, input hsize_t size, input hdata_t wdata);
        int        waits;
        logic      resp_wait;
        logic      resp_end;
        hdata_t    rdata;
        switches_t sw_snap;
        buttons_t  btn_snap;
        if (!timed_out) begin
            waits     = 0;
            resp_wait = 1'b0;
            @(negedge HCLK);
            sw_snap  = sw_q2;  // GPIO captures inputs in its wait cycle.
            btn_snap = btn_q2;
            check_board_outputs();
            while (!hready && waits < TIMEOUT) begin
                resp_wait = resp_wait | hresp;
                waits++;
                @(negedge HCLK);
                check_board_outputs();
            end
            if (!hready) begin
                errors++;
                timed_out = 1'b1;
                $display("Timeout: hready stayed low for %0d cycles at %0t", TIMEOUT, $time);
            end else begin
                rdata    = hrdata;
                resp_end = hresp;
                @(posedge HCLK);
                if (d_valid) begin
                    complete_data(waits, resp_wait, resp_end, rdata, sw_snap, btn_snap);
                end
                d_valid = a_valid;
                d_kind  = a_kind;
                d_write = a_write;
                d_addr  = a_addr;
                d_size  = a_size;
                d_wdata = a_wdata;
                a_valid = valid;
                a_kind  = kind;
                a_write = write;
                a_addr  = addr;
                a_size  = size;
                a_wdata = wdata;
                haddr  <= addr;
                htrans <= valid ? NONSEQ : IDLE;
                hsize  <= size;
                hwrite <= write;
                hwdata <= d_wdata;
            end
        end
    endtask

    task automatic idle_cycle();
        bus_step(1'b0, K_RAM, 1'b0, '0, SIZE_WORD, '0);
    endtask

    task automatic random_op(input int kind);
        logic   wr;
        int     idx;
        haddr_t addr;
        wr  = 1'(rand_bits(1));
        idx = int'(rand_bits(4));
        if (kind == K_GPIO) addr = GPIO_BASE + haddr_t'(4 * (idx % 5));
        else if (kind == K_ERR) addr = HOLE_BASE + haddr_t'(4 * idx);
        else addr = region_base(kind) + haddr_t'(4 * idx);
        bus_step(1'b1, kind, wr, addr, SIZE_WORD, rand_bits(32));
    endtask

    // Sub-word write, then a word read of the same location.
    task automatic lane_test();
        int         kind;
        hsize_t     size;
        logic [1:0] ofs;
        haddr_t     base;
        kind = rand_bits(1) ? K_BOOT : K_RAM;
        base = region_base(kind) + haddr_t'(4 * int'(rand_bits(4)));
        size = rand_bits(1) ? SIZE_HALF : SIZE_BYTE;
        ofs  = 2'(rand_bits(2));
        if (size == SIZE_HALF) ofs[0] = 1'b0;
        bus_step(1'b1, kind, 1'b1, base + haddr_t'(ofs), size, rand_bits(32));
        bus_step(1'b1, kind, 1'b0, base, SIZE_WORD, '0);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [2:0] pick;
        rst_n    = 1'b0;
        haddr    = '0;
        htrans   = IDLE;
        hsize    = SIZE_WORD;
        hwrite   = 1'b0;
        hwdata   = '0;
        switches = '0;
        buttons  = '0;
        red_m    = '0;
        green_m  = '0;
        hex_m    = '0;
        d_valid  = 1'b0;
        a_valid  = 1'b0;
        lfsr     = 16'd27695;
        errors   = 0;
        checks   = 0;
        timed_out = 1'b0;
        repeat (8) @(posedge HCLK);
        rst_n <= 1'b1;

        for (int i = 0; i < WIN; i++) begin
            bus_step(1'b1, K_BOOT, 1'b1, BOOT_BASE + haddr_t'(4 * i), SIZE_WORD, rand_bits(32));
            bus_step(1'b1, K_RAM, 1'b1, RAM_BASE + haddr_t'(4 * i), SIZE_WORD, rand_bits(32));
        end
        repeat (40) random_op(rand_bits(1) ? K_BOOT : K_RAM);
        repeat (30) lane_test();

        for (int r = 0; r < 3; r++) begin
            bus_step(1'b1, K_GPIO, 1'b1, GPIO_BASE + haddr_t'(4 * r), SIZE_WORD, rand_bits(32));
            bus_step(1'b1, K_GPIO, 1'b0, GPIO_BASE + haddr_t'(4 * r), SIZE_WORD, '0);
        end

        repeat (8) begin
            switches <= 16'(rand_bits(16));
            buttons  <= 4'(rand_bits(4));
            repeat (3) idle_cycle();
            bus_step(1'b1, K_GPIO, 1'b0, GPIO_BASE + haddr_t'(`GPIO_SW_OFS), SIZE_WORD, '0);
            bus_step(1'b1, K_GPIO, 1'b0, GPIO_BASE + haddr_t'(`GPIO_BTN_OFS), SIZE_WORD, '0);
        end

        bus_step(1'b1, K_ERR, 1'b0, HOLE_BASE, SIZE_WORD, '0);
        bus_step(1'b1, K_RAM, 1'b0, RAM_BASE, SIZE_WORD, '0);
        bus_step(1'b1, K_ERR, 1'b1, HOLE_BASE + 32'h4, SIZE_WORD, rand_bits(32));
        bus_step(1'b1, K_BOOT, 1'b0, BOOT_BASE, SIZE_WORD, '0);

        for (int n = 0; n < 80; n++) begin
            pick = 3'(rand_bits(3));
            case (pick)
                3'd5:    lane_test();
                3'd6:    random_op(K_GPIO);
                3'd7:    random_op(K_ERR);
                default: random_op(pick[0] ? K_RAM : K_BOOT);
            endcase
        end
        repeat (2) idle_cycle();

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
